// File: logic/seg_clock_pkg.sv
package seg_clock_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths with a meaning
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [4:0] hour_t;   // binary hours 0..23
    typedef logic [5:0] min_t;    // binary minutes or seconds 0..59
    typedef logic [3:0] bcd_t;    // one decimal digit

    // segment bits, active low
    // bit 0 = a, bit 1 = b ... bit 6 = g
    typedef logic [6:0] seg_t;

    typedef logic [3:0] an_t;     // anode enables, active low, bit 0 = rightmost digit
    typedef logic [1:0] scan_t;   // index of the digit being driven

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operating modes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        MODE_RUN         = 2'd0,
        MODE_SET_HOURS   = 2'd1,
        MODE_SET_MINUTES = 2'd2
    } mode_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counting limits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam hour_t HOURS_MAX = 5'd23;
    localparam min_t  MIN_MAX   = 6'd59;   // shared by minutes and seconds

    // prescaler divisors for a 100 MHz clock
    localparam int TICK_DIV_DEFAULT = 100_000_000;   // one second
    localparam int SCAN_DIV_DEFAULT = 100_000;       // 1 kHz digit step

endpackage

// File: logic/tick_gen.sv
`timescale 1ns/1ns

module tick_gen #(
    parameter int TICK_DIV = seg_clock_pkg::TICK_DIV_DEFAULT,
    parameter int SCAN_DIV = seg_clock_pkg::SCAN_DIV_DEFAULT
) (
    input  logic clk_100MHz,
    input  logic rst,
    input  logic sec_clear,
    output logic sec_tick,
    output logic scan_tick
);

    localparam int SEC_W  = $clog2(TICK_DIV + 1);
    localparam int SCAN_W = $clog2(SCAN_DIV + 1);

    logic [SEC_W-1:0]  sec_cnt;
    logic [SCAN_W-1:0] scan_cnt;

    // seconds prescaler, held at its reload value while the time is being set
    always_ff @(posedge clk_100MHz) begin
        if (rst || sec_clear) begin
            sec_cnt  <= SEC_W'(TICK_DIV - 1);
            sec_tick <= 1'b0;
        end else if (sec_cnt == '0) begin
            sec_cnt  <= SEC_W'(TICK_DIV - 1);   // reload
            sec_tick <= 1'b1;
        end else begin
            sec_cnt  <= sec_cnt - 1'b1;
            sec_tick <= 1'b0;
        end
    end

    // digit scan prescaler, free running
    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            scan_cnt  <= SCAN_W'(SCAN_DIV - 1);
            scan_tick <= 1'b0;
        end else if (scan_cnt == '0) begin
            scan_cnt  <= SCAN_W'(SCAN_DIV - 1);
            scan_tick <= 1'b1;
        end else begin
            scan_cnt  <= scan_cnt - 1'b1;
            scan_tick <= 1'b0;
        end
    end

endmodule

// File: logic/set_mode_fsm.sv
`timescale 1ns/1ns

module set_mode_fsm (
    input  logic                 clk_100MHz,
    input  logic                 rst,
    input  logic                 btn_mode,
    input  logic                 btn_inc,
    output seg_clock_pkg::mode_t mode,
    output logic                 run_enable,
    output logic                 sec_clear,
    output logic                 inc_hours,
    output logic                 inc_minutes
);

    import seg_clock_pkg::*;

    mode_t mode_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mode sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // run -> set hours -> set minutes -> run
    always_comb begin
        mode_next = mode;
        if (btn_mode) begin
            case (mode)
                MODE_RUN:         mode_next = MODE_SET_HOURS;
                MODE_SET_HOURS:   mode_next = MODE_SET_MINUTES;
                MODE_SET_MINUTES: mode_next = MODE_RUN;
                default:          mode_next = MODE_RUN;
            endcase
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            mode <= MODE_RUN;
        end else begin
            mode <= mode_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // increment commands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one-cycle strobes, decided by the mode in force when btn_inc arrives
    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            inc_hours   <= 1'b0;
            inc_minutes <= 1'b0;
        end else begin
            inc_hours   <= btn_inc && (mode == MODE_SET_HOURS);
            inc_minutes <= btn_inc && (mode == MODE_SET_MINUTES);
        end
    end

    // seconds only count while running
    always_comb begin
        run_enable = (mode == MODE_RUN);
        sec_clear  = !run_enable;   // restart the second when leaving set mode
    end

endmodule

// File: logic/time_counter.sv
`timescale 1ns/1ns

module time_counter (
    input  logic                 clk_100MHz,
    input  logic                 rst,
    input  logic                 sec_tick,
    input  logic                 run_enable,
    input  logic                 inc_hours,
    input  logic                 inc_minutes,
    output seg_clock_pkg::min_t  seconds,
    output seg_clock_pkg::min_t  minutes,
    output seg_clock_pkg::hour_t hours
);

    import seg_clock_pkg::*;

    logic sec_step;
    logic sec_wrap;
    logic min_step;
    logic min_wrap;
    logic hour_step;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // carry chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        sec_step = run_enable && sec_tick;
        sec_wrap = sec_step && (seconds == MIN_MAX);

        // set commands bump their field but never carry on
        min_step = sec_wrap || inc_minutes;
        min_wrap = sec_wrap && (minutes == MIN_MAX);

        hour_step = min_wrap || inc_hours;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // time registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            seconds <= '0;
        end else if (!run_enable) begin
            seconds <= '0;                   // held while setting
        end else if (sec_step) begin
            if (seconds == MIN_MAX) begin
                seconds <= '0;
            end else begin
                seconds <= seconds + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            minutes <= '0;
        end else if (min_step) begin
            if (minutes == MIN_MAX) begin
                minutes <= '0;
            end else begin
                minutes <= minutes + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            hours <= '0;
        end else if (hour_step) begin
            if (hours == HOURS_MAX) begin
                hours <= '0;                 // 23 -> 00
            end else begin
                hours <= hours + 1'b1;
            end
        end
    end

endmodule

// File: logic/digit_split.sv
`timescale 1ns/1ns

module digit_split (
    input  logic                 clk_100MHz,
    input  logic                 rst,
    input  seg_clock_pkg::hour_t hours,
    input  seg_clock_pkg::min_t  minutes,
    output seg_clock_pkg::bcd_t  hour_tens,
    output seg_clock_pkg::bcd_t  hour_ones,
    output seg_clock_pkg::bcd_t  min_tens,
    output seg_clock_pkg::bcd_t  min_ones
);

    import seg_clock_pkg::*;

    // tens digit by threshold compare, good for 0..59
    function automatic bcd_t tens_of(input min_t value);
        if      (value >= 6'd50) return 4'd5;
        else if (value >= 6'd40) return 4'd4;
        else if (value >= 6'd30) return 4'd3;
        else if (value >= 6'd20) return 4'd2;
        else if (value >= 6'd10) return 4'd1;
        else                     return 4'd0;
    endfunction

    function automatic bcd_t ones_of(input min_t value, input bcd_t tens);
        return bcd_t'(value - min_t'(tens) * 6'd10);
    endfunction

    min_t hours_ext;
    bcd_t h_tens;
    bcd_t m_tens;

    always_comb begin
        hours_ext = min_t'(hours);
        h_tens    = tens_of(hours_ext);
        m_tens    = tens_of(minutes);
    end

    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            hour_tens <= '0;
            hour_ones <= '0;
            min_tens  <= '0;
            min_ones  <= '0;
        end else begin
            hour_tens <= h_tens;
            hour_ones <= ones_of(hours_ext, h_tens);
            min_tens  <= m_tens;
            min_ones  <= ones_of(minutes, m_tens);
        end
    end

endmodule

// File: logic/display_scan.sv
`timescale 1ns/1ns

module display_scan (
    input  logic                 clk_100MHz,
    input  logic                 rst,
    input  logic                 scan_tick,
    input  seg_clock_pkg::mode_t mode,
    input  seg_clock_pkg::min_t  seconds,
    input  seg_clock_pkg::bcd_t  hour_tens,
    input  seg_clock_pkg::bcd_t  hour_ones,
    input  seg_clock_pkg::bcd_t  min_tens,
    input  seg_clock_pkg::bcd_t  min_ones,
    output seg_clock_pkg::seg_t  seg,
    output logic                 dp,
    output seg_clock_pkg::an_t   an
);

    import seg_clock_pkg::*;

    scan_t idx;
    bcd_t  digit;
    seg_t  seg_next;
    logic  dp_lit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // digit select and decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (idx)
            2'd0:    digit = min_ones;   // rightmost
            2'd1:    digit = min_tens;
            2'd2:    digit = hour_ones;
            default: digit = hour_tens;
        endcase
    end

    // gfedcba, low = segment on
    always_comb begin
        case (digit)
            4'd0:    seg_next = 7'b100_0000;
            4'd1:    seg_next = 7'b111_1001;
            4'd2:    seg_next = 7'b010_0100;
            4'd3:    seg_next = 7'b011_0000;
            4'd4:    seg_next = 7'b001_1001;
            4'd5:    seg_next = 7'b001_0010;
            4'd6:    seg_next = 7'b000_0010;
            4'd7:    seg_next = 7'b111_1000;
            4'd8:    seg_next = 7'b000_0000;
            4'd9:    seg_next = 7'b001_0000;
            default: seg_next = 7'b111_1111;   // blank
        endcase
    end

    // dp marks the field being set, or blinks with the seconds when running
    always_comb begin
        case (mode)
            MODE_SET_HOURS:   dp_lit = idx[1];
            MODE_SET_MINUTES: dp_lit = !idx[1];
            default:          dp_lit = (idx == 2'd2) && seconds[0];
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            idx <= '0;
            seg <= '1;
            dp  <= 1'b1;
            an  <= '1;                       // all digits dark
        end else if (scan_tick) begin
            seg <= seg_next;
            dp  <= !dp_lit;
            an  <= ~(an_t'(1) << idx);       // one-cold
            idx <= idx + 1'b1;
        end
    end

endmodule

// File: logic/seg_clock_top.sv
`timescale 1ns/1ns

module seg_clock_top #(
    parameter int TICK_DIV = seg_clock_pkg::TICK_DIV_DEFAULT,
    parameter int SCAN_DIV = seg_clock_pkg::SCAN_DIV_DEFAULT
) (
    input  logic                clk_100MHz,
    input  logic                rst,
    input  logic                btn_mode,
    input  logic                btn_inc,
    output seg_clock_pkg::seg_t seg,
    output logic                dp,
    output seg_clock_pkg::an_t  an
);

    import seg_clock_pkg::*;

    logic  sec_tick;
    logic  scan_tick;
    logic  sec_clear;
    logic  run_enable;
    logic  inc_hours;
    logic  inc_minutes;
    mode_t mode;
    min_t  seconds;
    min_t  minutes;
    hour_t hours;
    bcd_t  hour_tens;
    bcd_t  hour_ones;
    bcd_t  min_tens;
    bcd_t  min_ones;

    tick_gen #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) u_tick_gen (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .sec_clear  (sec_clear),
        .sec_tick   (sec_tick),
        .scan_tick  (scan_tick)
    );

    set_mode_fsm u_set_mode_fsm (
        .clk_100MHz  (clk_100MHz),
        .rst         (rst),
        .btn_mode    (btn_mode),
        .btn_inc     (btn_inc),
        .mode        (mode),
        .run_enable  (run_enable),
        .sec_clear   (sec_clear),
        .inc_hours   (inc_hours),
        .inc_minutes (inc_minutes)
    );

    time_counter u_time_counter (
        .clk_100MHz  (clk_100MHz),
        .rst         (rst),
        .sec_tick    (sec_tick),
        .run_enable  (run_enable),
        .inc_hours   (inc_hours),
        .inc_minutes (inc_minutes),
        .seconds     (seconds),
        .minutes     (minutes),
        .hours       (hours)
    );

    digit_split u_digit_split (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .hours      (hours),
        .minutes    (minutes),
        .hour_tens  (hour_tens),
        .hour_ones  (hour_ones),
        .min_tens   (min_tens),
        .min_ones   (min_ones)
    );

    display_scan u_display_scan (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .scan_tick  (scan_tick),
        .mode       (mode),
        .seconds    (seconds),
        .hour_tens  (hour_tens),
        .hour_ones  (hour_ones),
        .min_tens   (min_tens),
        .min_ones   (min_ones),
        .seg        (seg),
        .dp         (dp),
        .an         (an)
    );

endmodule

// File: sim/seg_clock_tb.sv
`timescale 1ns/1ns

module seg_clock_tb;

    import seg_clock_pkg::*;

    localparam int TICK_DIV  = 64;
    localparam int SCAN_DIV  = 4;
    localparam int DISP_WAIT = 8 * SCAN_DIV + 8;   // two full scans plus pipeline
    localparam int MIN_WAIT  = 61 * TICK_DIV;

    logic clk_100MHz;
    logic rst;
    logic btn_mode;
    logic btn_inc;
    seg_t seg;
    logic dp;
    an_t  an;

    seg_clock_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) dut (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .btn_mode   (btn_mode),
        .btn_inc    (btn_inc),
        .seg        (seg),
        .dp         (dp),
        .an         (an)
    );

    int          cycle = 0;
    int          sec_phase;
    int          scan_phase;
    logic        sec_tick_m;
    logic        scan_tick_m;
    mode_t       mode_m;
    logic        inc_hours_m;
    logic        inc_minutes_m;
    logic        min_carry;
    logic        hour_carry;
    int          sec_m;
    int          min_m;
    int          hour_m;
    int          digits_m [4];   // 0 = minute ones ... 3 = hour tens
    int          idx_m;
    an_t         exp_an;
    logic        exp_dp;
    logic        exp_blank;
    int          exp_digit;
    int          exp_pos;
    int          shown [4];      // last digit decoded at each position
    int          got;
    logic [31:0] rng_state;

    always #20 clk_100MHz = ~clk_100MHz;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // common-anode patterns, gfedcba with low = on
    function automatic int decode_seg(input seg_t s);
        case (s)
            7'h40:   return 0;
            7'h79:   return 1;
            7'h24:   return 2;
            7'h30:   return 3;
            7'h19:   return 4;
            7'h12:   return 5;
            7'h02:   return 6;
            7'h78:   return 7;
            7'h00:   return 8;
            7'h10:   return 9;
            default: return 15;              // not a digit
        endcase
    endfunction

    // one anode low per scan position, bit 0 = rightmost digit
    function automatic an_t anode_for(input int pos);
        case (pos)
            0:       return 4'b1110;
            1:       return 4'b1101;
            2:       return 4'b1011;
            default: return 4'b0111;
        endcase
    endfunction

    function automatic mode_t next_mode(input mode_t m);
        case (m)
            MODE_RUN:       return MODE_SET_HOURS;
            MODE_SET_HOURS: return MODE_SET_MINUTES;
            default:        return MODE_RUN;
        endcase
    endfunction

    function automatic logic dp_lit(input mode_t m, input int pos, input int secs);
        case (m)
            MODE_SET_HOURS:   return pos >= 2;
            MODE_SET_MINUTES: return pos <= 1;
            default:          return (pos == 2) && (secs % 2 == 1);
        endcase
    endfunction

    function automatic logic display_is(input int hh, input int mm);
        return shown[3] == hh / 10 && shown[2] == hh % 10
            && shown[1] == mm / 10 && shown[0] == mm % 10;
    endfunction

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        end_with_failure($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act));
    endtask

    task automatic step();
        @(posedge clk_100MHz);
        #1;
    endtask

    task automatic press_mode();
        btn_mode = 1'b1;
        step();
        btn_mode = 1'b0;
    endtask

    // one strobe, then a random idle gap of 0 to 7 cycles
    task automatic press_inc();
        btn_inc = 1'b1;
        step();
        btn_inc   = 1'b0;
        rng_state = xorshift32(rng_state);
        repeat (rng_state % 8) step();
    endtask

    task automatic wait_for_display(input int hh, input int mm, input int limit);
        int waited;
        waited = 0;
        while (!display_is(hh, mm) && waited < limit) begin
            step();
            waited++;
        end
        if (!display_is(hh, mm)) begin
            end_with_failure($sformatf("display did not show %02d:%02d within %0d cycles",
                                       hh, mm, limit));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        min_carry  = (mode_m == MODE_RUN) && sec_tick_m && (sec_m == 59);
        hour_carry = min_carry && (min_m == 59);
    end

    always @(posedge clk_100MHz) begin
        cycle <= cycle + 1;
        if (rst) begin
            sec_phase     <= 0;
            scan_phase    <= 0;
            sec_tick_m    <= 1'b0;
            scan_tick_m   <= 1'b0;
            mode_m        <= MODE_RUN;
            inc_hours_m   <= 1'b0;
            inc_minutes_m <= 1'b0;
            sec_m         <= 0;
            min_m         <= 0;
            hour_m        <= 0;
            digits_m[0]   <= 0;
            digits_m[1]   <= 0;
            digits_m[2]   <= 0;
            digits_m[3]   <= 0;
            idx_m         <= 0;
            exp_an        <= '1;
            exp_dp        <= 1'b1;
            exp_blank     <= 1'b1;
        end else begin
            // a second starts over whenever the time is being set
            if (mode_m != MODE_RUN || sec_phase == TICK_DIV - 1) begin
                sec_phase <= 0;
            end else begin
                sec_phase <= sec_phase + 1;
            end
            sec_tick_m  <= (mode_m == MODE_RUN) && (sec_phase == TICK_DIV - 1);
            scan_phase  <= (scan_phase + 1) % SCAN_DIV;
            scan_tick_m <= (scan_phase == SCAN_DIV - 1);

            if (btn_mode) begin
                mode_m <= next_mode(mode_m);
            end
            inc_hours_m   <= btn_inc && (mode_m == MODE_SET_HOURS);
            inc_minutes_m <= btn_inc && (mode_m == MODE_SET_MINUTES);

            if (mode_m != MODE_RUN) begin
                sec_m <= 0;
            end else if (sec_tick_m) begin
                sec_m <= (sec_m + 1) % 60;
            end
            if (min_carry || inc_minutes_m) min_m <= (min_m + 1) % 60;
            if (hour_carry || inc_hours_m) hour_m <= (hour_m + 1) % 24;

            digits_m[0] <= min_m % 10;
            digits_m[1] <= min_m / 10;
            digits_m[2] <= hour_m % 10;
            digits_m[3] <= hour_m / 10;

            if (scan_tick_m) begin
                exp_an    <= anode_for(idx_m);
                exp_digit <= digits_m[idx_m];
                exp_pos   <= idx_m;
                exp_dp    <= !dp_lit(mode_m, idx_m, sec_m);
                exp_blank <= 1'b0;
                idx_m     <= (idx_m + 1) % 4;
            end
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk_100MHz) begin
        if (cycle > 0) begin
            assert (an === exp_an) else report_mismatch("an", exp_an, an);
            assert (dp === exp_dp) else report_mismatch("dp", exp_dp, dp);
            if (exp_blank) begin
                assert (seg === 7'h7f) else report_mismatch("seg", 32'h7f, seg);
            end else begin
                got = decode_seg(seg);
                assert (got == exp_digit) else report_mismatch("digit", exp_digit, got);
                shown[exp_pos] = got;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int n;
        int exp_h;
        int exp_m;
        int start;
        int took;
        clk_100MHz = 1'b0;
        rst        = 1'b1;
        btn_mode   = 1'b0;
        btn_inc    = 1'b0;
        rng_state  = 32'h3ab9;
        for (int i = 0; i < 4; i++) begin
            shown[i] = 15;
        end
        repeat (10) @(posedge clk_100MHz);
        #1 rst = 1'b0;

        wait_for_display(0, 0, DISP_WAIT);
        wait_for_display(0, 1, MIN_WAIT);           // first minute while running

        press_mode();                               // set hours
        rng_state = xorshift32(rng_state);
        n = 20 + rng_state % 10;
        repeat (n) press_inc();
        exp_h = n % 24;
        wait_for_display(exp_h, 1, DISP_WAIT);
        repeat ((23 - exp_h + 24) % 24) press_inc();
        wait_for_display(23, 1, DISP_WAIT);

        press_mode();                               // set minutes, wraps past 59
        rng_state = xorshift32(rng_state);
        n = 61 + rng_state % 5;
        repeat (n) press_inc();
        exp_m = (1 + n) % 60;
        wait_for_display(23, exp_m, DISP_WAIT);
        repeat ((59 - exp_m + 60) % 60) press_inc();
        wait_for_display(23, 59, DISP_WAIT);

        start = cycle;
        press_mode();                               // back to run
        wait_for_display(0, 0, MIN_WAIT);
        took = cycle - start;
        if (took < 60 * TICK_DIV || took > 60 * TICK_DIV + DISP_WAIT) begin
            end_with_failure($sformatf("rollover came %0d cycles after leaving set mode",
                                       took));
        end

        press_inc();                                // ignored while running
        repeat (DISP_WAIT) step();
        if (!display_is(0, 0)) begin
            end_with_failure("an increment press in run mode changed the time");
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: seg_clock.f
logic/seg_clock_pkg.sv
logic/tick_gen.sv
logic/set_mode_fsm.sv
logic/time_counter.sv
logic/digit_split.sv
logic/display_scan.sv
logic/seg_clock_top.sv
sim/seg_clock_tb.sv
